// File: bench/drum_tb.sv
`timescale 1ns/1ps

module drum_tb;
	import drum_pkg::*;

	localparam int MAX_ACK_DELAY = 5;
	localparam int ZERO_STEPS    = 5;
	localparam int MODEL_STEPS   = 20;
	localparam int LOAD_CYCLES   = GRID_ROWS * GRID_COLS * 2 + 8 + 4;
	localparam int LIMIT = (ZERO_STEPS + MODEL_STEPS) * (STEP_CYCLES + MAX_ACK_DELAY + 10)
		+ 2 * LOAD_CYCLES;

	logic clk;
	logic rst;
	logic load_req;
	row_t load_row;
	col_t load_col;
	node_t load_data;
	logic load_ack;
	logic sample_req;
	node_t sample_data;
	logic sample_ack;
	cycles_t step_cycles;

	// testbench state
	logic [31:0] lcg_state;
	logic loading;
	logic load_seen;
	logic sample_req_q;
	int errors;
	int samples_seen;
	int cycle_count;
	node_t exp_sample;
	node_t model_center;
	node_t init_grid [GRID_ROWS][GRID_COLS];
	node_t cur [GRID_ROWS][GRID_COLS];
	node_t prv [GRID_ROWS][GRID_COLS];
	node_t nxt [GRID_ROWS][GRID_COLS];

	drum_top u_drum_top (
		.clk         (clk),
		.rst         (rst),
		.load_req    (load_req),
		.load_row    (load_row),
		.load_col    (load_col),
		.load_data   (load_data),
		.load_ack    (load_ack),
		.sample_req  (sample_req),
		.sample_data (sample_data),
		.sample_ack  (sample_ack),
		.step_cycles (step_cycles)
	);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// about +-1/64 of full scale
	function automatic node_t small_random();
		logic [31:0] r;
		r = next_random();
		return {{6{r[23]}}, r[23:12]};
	endfunction

	// keep sign, then the 17 bits below bit 34
	function automatic node_t fixed_mul(input node_t a, input node_t b);
		logic signed [35:0] wide;
		wide = 36'(a) * 36'(b);
		return {wide[35], wide[33:17]};
	endfunction

	function automatic node_t tension(input node_t center);
		node_t scaled;
		node_t rho;
		scaled = center >>> GAIN_SHIFT;
		rho = fixed_mul(scaled, scaled) + RHO_0;
		if (rho > RHO_MAX)
			rho = RHO_MAX;
		return rho;
	endfunction

	function automatic node_t next_value(input node_t c, input node_t p, input node_t l,
		input node_t r, input node_t d, input node_t u, input node_t rho);
		node_t lap;
		node_t sum;
		lap = l + r + d + u - 18'sd4 * c;
		sum = 18'sd2 * c + fixed_mul(rho, lap) - p + (p >>> DAMP_SHIFT);
		return sum - (sum >>> DAMP_SHIFT);
	endfunction

	// one time step over the whole grid, zero outside the edges
	task automatic model_step();
		node_t rho;
		node_t l;
		node_t r;
		node_t d;
		node_t u;
		rho = tension(model_center);
		for (int y = 0; y < GRID_ROWS; y++) begin
			for (int x = 0; x < GRID_COLS; x++) begin
				l = (x > 0) ? cur[y][x - 1] : '0;
				r = (x < GRID_COLS - 1) ? cur[y][x + 1] : '0;
				d = (y > 0) ? cur[y - 1][x] : '0;
				u = (y < GRID_ROWS - 1) ? cur[y + 1][x] : '0;
				nxt[y][x] = next_value(cur[y][x], prv[y][x], l, r, d, u, rho);
			end
		end
		prv = cur;
		cur = nxt;
		model_center = cur[CENTER_ROW][CENTER_COL];
		exp_sample = model_center;
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		load_seen = 1'b0;
		repeat (8) step();
		rst = 1'b0;
	endtask

	task automatic load_cell(input int r, input int c, input node_t v);
		load_row = row_t'(r);
		load_col = col_t'(c);
		load_data = v;
		load_req = 1'b1;
		load_seen = 1'b1;
		do step(); while (!load_ack);
		load_req = 1'b0;
		do step(); while (load_ack);
	endtask

	// row-major, so the last cell closes the load
	task automatic load_grid();
		loading = 1'b1;
		for (int y = 0; y < GRID_ROWS; y++)
			for (int x = 0; x < GRID_COLS; x++)
				load_cell(y, x, init_grid[y][x]);
		loading = 1'b0;
		cur = init_grid;
		prv = init_grid;
		model_center = '0;
	endtask

	task automatic run_steps(input int n);
		int delay;
		for (int k = 0; k < n; k++) begin
			model_step();
			do step(); while (!sample_req);
			delay = int'(next_random() >> 16) % (MAX_ACK_DELAY + 1);
			repeat (delay) step();
			sample_ack = 1'b1;
			do step(); while (sample_req);
			sample_ack = 1'b0;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// rising sample_req edges as the DUT presents them
	always @(posedge clk) begin
		if (sample_req && !sample_req_q)
			samples_seen++;
		sample_req_q <= sample_req;
	end

	assert property (@(posedge clk) disable iff (rst)
		!load_seen |-> (!load_ack && !sample_req && step_cycles == '0))
		else begin
			errors++;
			$display("error: idle load_ack %h sample_req %h step_cycles %h",
				load_ack, sample_req, step_cycles);
		end

	assert property (@(posedge clk) disable iff (rst) $rose(load_ack) |-> $past(load_req))
		else begin
			errors++;
			$display("error: load_ack rose to %h with load_req %h", load_ack, load_req);
		end

	assert property (@(posedge clk) disable iff (rst) $fell(load_ack) |-> !$past(load_req))
		else begin
			errors++;
			$display("error: load_ack fell to %h while load_req was high", load_ack);
		end

	// one cycle each way while loading
	assert property (@(posedge clk) disable iff (rst)
		loading && $past(load_req) && !$past(load_ack) |-> load_ack)
		else begin
			errors++;
			$display("error: load_ack %h expected 1", load_ack);
		end

	assert property (@(posedge clk) disable iff (rst)
		loading && !$past(load_req) && $past(load_ack) |-> !load_ack)
		else begin
			errors++;
			$display("error: load_ack %h expected 0", load_ack);
		end

	assert property (@(posedge clk) disable iff (rst)
		$rose(sample_req) |-> sample_data == exp_sample)
		else begin
			errors++;
			$display("error: sample_data %h expected %h", sample_data, exp_sample);
		end

	assert property (@(posedge clk) disable iff (rst)
		$rose(sample_req) |-> step_cycles == cycles_t'(STEP_CYCLES))
		else begin
			errors++;
			$display("error: step_cycles %h expected %h", step_cycles,
				cycles_t'(STEP_CYCLES));
		end

	assert property (@(posedge clk) disable iff (rst)
		$past(sample_req) && sample_req |-> $stable(sample_data))
		else begin
			errors++;
			$display("error: sample_data %h changed while sample_req high", sample_data);
		end

	assert property (@(posedge clk) disable iff (rst)
		$past(sample_req) && !$past(sample_ack) |-> sample_req)
		else begin
			errors++;
			$display("error: sample_req %h dropped before sample_ack", sample_req);
		end

	assert property (@(posedge clk) disable iff (rst)
		$past(sample_req) && $past(sample_ack) |-> !sample_req)
		else begin
			errors++;
			$display("error: sample_req %h expected 0 after sample_ack", sample_req);
		end

	// watchdog
	initial begin
		cycle_count = 0;
		while (cycle_count < LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: run did not finish within %0d cycles", LIMIT);
		$display("summary: %0d errors, %0d samples", errors, samples_seen);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		load_req = 1'b0;
		load_row = '0;
		load_col = '0;
		load_data = '0;
		sample_ack = 1'b0;
		loading = 1'b0;
		load_seen = 1'b0;
		sample_req_q = 1'b0;
		errors = 0;
		samples_seen = 0;
		exp_sample = '0;
		model_center = '0;
		lcg_state = 32'he3c7_3bee;

		// flat membrane stays silent
		apply_reset();
		for (int y = 0; y < GRID_ROWS; y++)
			for (int x = 0; x < GRID_COLS; x++)
				init_grid[y][x] = '0;
		load_grid();
		run_steps(ZERO_STEPS);

		// strike at the center over a little noise
		apply_reset();
		for (int y = 0; y < GRID_ROWS; y++)
			for (int x = 0; x < GRID_COLS; x++)
				init_grid[y][x] = small_random();
		init_grid[CENTER_ROW][CENTER_COL] = 18'sh0c000;
		load_grid();
		run_steps(MODEL_STEPS);
		step();

		if (samples_seen != ZERO_STEPS + MODEL_STEPS) begin
			errors++;
			$display("received %0d samples instead of %0d", samples_seen,
				ZERO_STEPS + MODEL_STEPS);
		end
		$display("summary: %0d errors, %0d samples", errors, samples_seen);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the drum testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module drum_tb \
	-Mdir obj_dir -f sim.f > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/Vdrum_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' sim.log; then
	exit 1
fi
exit 0

// File: sim.f
src/drum_pkg.sv
src/node_update.sv
src/tension_calc.sv
src/drum_column.sv
src/row_counter.sv
src/sweep_fsm.sv
src/drum_top.sv
bench/drum_tb.sv

// File: src/drum_column.sv
`timescale 1ns/1ps

module drum_column (
	input  logic            clk,
	input  logic            rst,
	input  drum_pkg::row_t  row,
	input  logic            start_sweep,
	input  logic            write_phase,
	input  logic            shift_phase,
	input  logic            load_we,
	input  drum_pkg::row_t  load_row,
	input  drum_pkg::node_t load_data,
	input  drum_pkg::node_t rho_eff,
	input  drum_pkg::node_t left,
	input  drum_pkg::node_t right,
	output drum_pkg::node_t node_cur,
	output drum_pkg::node_t node_next
);
	import drum_pkg::*;

	node_t cur_mem [GRID_ROWS];
	node_t prev_mem [GRID_ROWS];
	node_t rd_cur;
	node_t rd_prev;
	node_t u_cur;
	node_t u_below;
	node_t bottom;
	node_t u_next;
	node_t u_down;
	node_t u_up;
	logic  last_row;
	logic  mem_we;
	row_t  wr_addr;
	row_t  rd_addr;

	assign last_row = (row == row_t'(GRID_ROWS - 1));

	// read ahead one row, wrapping to the bottom for the next step
	assign rd_addr = last_row ? '0 : row + 1'b1;
	assign mem_we  = load_we | write_phase;
	assign wr_addr = load_we ? load_row : row;

	always_ff @(posedge clk) begin
		if (mem_we) begin
			cur_mem[wr_addr]  <= load_we ? load_data : u_next;
			prev_mem[wr_addr] <= load_we ? load_data : u_cur;
		end
		rd_cur  <= cur_mem[rd_addr];
		rd_prev <= prev_mem[row];
	end

	// zero outside the first and last rows
	assign u_down = (row == '0) ? '0 : u_below;
	assign u_up   = last_row ? '0 : rd_cur;

	node_update u_node_update (
		.u_cur   (u_cur),
		.u_prev  (rd_prev),
		.u_left  (left),
		.u_right (right),
		.u_down  (u_down),
		.u_up    (u_up),
		.rho_eff (rho_eff),
		.u_next  (u_next)
	);

	// row pipeline
	always_ff @(posedge clk) begin
		if (rst) begin
			u_cur   <= '0;
			u_below <= '0;
			bottom  <= '0;
		end else begin
			// bottom node seeds row 0 at the start of a sweep
			if (load_we && load_row == '0)
				bottom <= load_data;
			else if (write_phase && row == '0)
				bottom <= u_next;
			if (start_sweep) begin
				u_cur <= bottom;
			end else if (shift_phase) begin
				u_below <= u_cur;
				u_cur   <= rd_cur;
			end
		end
	end

	assign node_cur  = u_cur;
	assign node_next = u_next;

endmodule

// File: src/drum_pkg.sv
package drum_pkg;

	// grid geometry
	localparam int GRID_ROWS   = 8;
	localparam int GRID_COLS   = 8;
	localparam int CENTER_ROW  = 4;
	localparam int CENTER_COL  = 4;

	// sweep timing
	localparam int ROW_CYCLES  = 3;
	localparam int STEP_CYCLES = 2 + GRID_ROWS * ROW_CYCLES;

	typedef logic signed [17:0] node_t;
	typedef logic [$clog2(GRID_ROWS)-1:0] row_t;
	typedef logic [$clog2(GRID_COLS)-1:0] col_t;
	typedef logic [15:0] cycles_t;

	// 1.17 constants, 0.25 and about 0.49
	localparam node_t RHO_0   = 18'sh08000;
	localparam node_t RHO_MAX = 18'sh0fae1;
	localparam int DAMP_SHIFT = 10;
	localparam int GAIN_SHIFT = 4;

	typedef enum logic [3:0] {
		LOAD, SETTLE, START, READ_WAIT, WRITE, SHIFT, NEXT_ROW, SEND, RELEASE
	} sweep_state_t;

	// 1.17 signed product, sign bit then bits 33..17
	function automatic node_t fx_mul(input node_t a, input node_t b);
		logic signed [35:0] p;
		p = a * b;
		return {p[35], p[33:17]};
	endfunction

endpackage

// File: src/drum_top.sv
`timescale 1ns/1ps

module drum_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              load_req,
	input  drum_pkg::row_t    load_row,
	input  drum_pkg::col_t    load_col,
	input  drum_pkg::node_t   load_data,
	output logic              load_ack,
	output logic              sample_req,
	output drum_pkg::node_t   sample_data,
	input  logic              sample_ack,
	output drum_pkg::cycles_t step_cycles
);
	import drum_pkg::*;

	// node_cur of every column, padded with a zero on each side
	node_t cur_pad [GRID_COLS + 2];
	node_t next_bus [GRID_COLS];
	node_t rho_eff;
	node_t center_value;
	row_t  row;
	logic  row_last;
	logic  start_sweep;
	logic  read_wait;
	logic  write_phase;
	logic  shift_phase;
	logic  load_write;
	logic  freeze;

	assign cur_pad[0]             = '0;
	assign cur_pad[GRID_COLS + 1] = '0;

	// cycle count stops on the first cycle outside the sweep
	assign freeze = !(start_sweep || read_wait || write_phase || shift_phase);

	sweep_fsm u_sweep_fsm (
		.clk          (clk),
		.rst          (rst),
		.load_req     (load_req),
		.load_row     (load_row),
		.load_col     (load_col),
		.load_ack     (load_ack),
		.row          (row),
		.row_last     (row_last),
		.center_next  (next_bus[CENTER_COL]),
		.start_sweep  (start_sweep),
		.read_wait    (read_wait),
		.write_phase  (write_phase),
		.shift_phase  (shift_phase),
		.load_write   (load_write),
		.sample_req   (sample_req),
		.sample_ack   (sample_ack),
		.center_value (center_value)
	);

	row_counter u_row_counter (
		.clk         (clk),
		.rst         (rst),
		.start_sweep (start_sweep),
		.shift_phase (shift_phase),
		.freeze      (freeze),
		.row         (row),
		.row_last    (row_last),
		.step_cycles (step_cycles)
	);

	tension_calc u_tension_calc (
		.center_value (center_value),
		.rho_eff      (rho_eff)
	);

	//////////////////////////////////////////////////////////////////////
	// column array
	//////////////////////////////////////////////////////////////////////

	for (genvar c = 0; c < GRID_COLS; c++) begin : g_col
		logic load_we;

		assign load_we = load_write && (load_col == col_t'(c));

		drum_column u_drum_column (
			.clk         (clk),
			.rst         (rst),
			.row         (row),
			.start_sweep (start_sweep),
			.write_phase (write_phase),
			.shift_phase (shift_phase),
			.load_we     (load_we),
			.load_row    (load_row),
			.load_data   (load_data),
			.rho_eff     (rho_eff),
			.left        (cur_pad[c]),
			.right       (cur_pad[c + 2]),
			.node_cur    (cur_pad[c + 1]),
			.node_next   (next_bus[c])
		);
	end

	assign sample_data = center_value;

endmodule

// File: src/node_update.sv
`timescale 1ns/1ps

module node_update (
	input  drum_pkg::node_t u_cur,
	input  drum_pkg::node_t u_prev,
	input  drum_pkg::node_t u_left,
	input  drum_pkg::node_t u_right,
	input  drum_pkg::node_t u_down,
	input  drum_pkg::node_t u_up,
	input  drum_pkg::node_t rho_eff,
	output drum_pkg::node_t u_next
);
	import drum_pkg::*;

	node_t lap;
	node_t rho_lap;
	node_t undamped;
	node_t damped;

	//////////////////////////////////////////////////////////////////////
	// discrete laplacian, wraps in 18 bits like the rest of the datapath
	//////////////////////////////////////////////////////////////////////

	assign lap = u_left + u_right + u_down + u_up - (u_cur <<< 2);

	assign rho_lap = fx_mul(rho_eff, lap);

	//////////////////////////////////////////////////////////////////////
	// leapfrog step with light damping
	//////////////////////////////////////////////////////////////////////

	// 2u - u_prev, with a small part of u_prev kept back
	assign undamped = (u_cur <<< 1) + rho_lap - u_prev + (u_prev >>> DAMP_SHIFT);

	// energy loss of about 1/1024 per step
	assign damped = undamped - (undamped >>> DAMP_SHIFT);

	assign u_next = damped;

endmodule

// File: src/row_counter.sv
`timescale 1ns/1ps

module row_counter (
	input  logic              clk,
	input  logic              rst,
	input  logic              start_sweep,
	input  logic              shift_phase,
	input  logic              freeze,
	output drum_pkg::row_t    row,
	output logic              row_last,
	output drum_pkg::cycles_t step_cycles
);
	import drum_pkg::*;

	cycles_t count;
	logic    running;

	assign row_last = (row == row_t'(GRID_ROWS - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			row         <= '0;
			count       <= '0;
			running     <= 1'b0;
			step_cycles <= '0;
		end else begin
			if (start_sweep)
				row <= '0;
			else if (shift_phase)
				row <= row_last ? '0 : row + 1'b1;

			// start cycle counts as the first one
			if (start_sweep) begin
				count   <= cycles_t'(1);
				running <= 1'b1;
			end else if (running) begin
				if (freeze) begin
					step_cycles <= count;
					running     <= 1'b0;
				end else begin
					count <= count + 1'b1;
				end
			end
		end
	end

endmodule

// File: src/sweep_fsm.sv
`timescale 1ns/1ps

module sweep_fsm (
	input  logic            clk,
	input  logic            rst,
	input  logic            load_req,
	input  drum_pkg::row_t  load_row,
	input  drum_pkg::col_t  load_col,
	output logic            load_ack,
	input  drum_pkg::row_t  row,
	input  logic            row_last,
	input  drum_pkg::node_t center_next,
	output logic            start_sweep,
	output logic            read_wait,
	output logic            write_phase,
	output logic            shift_phase,
	output logic            load_write,
	output logic            sample_req,
	input  logic            sample_ack,
	output drum_pkg::node_t center_value
);
	import drum_pkg::*;

	sweep_state_t state;
	logic         load_last;
	logic         sweep_done;
	node_t        center_hold;

	// phase strobes
	assign start_sweep = (state == START);
	assign read_wait   = (state == READ_WAIT) || (state == NEXT_ROW);
	assign write_phase = (state == WRITE);
	assign shift_phase = (state == SHIFT);
	assign load_write  = (state == LOAD) && load_req && !load_ack;

	//////////////////////////////////////////////////////////////////////
	// sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= LOAD;
			load_ack     <= 1'b0;
			load_last    <= 1'b0;
			sweep_done   <= 1'b0;
			sample_req   <= 1'b0;
			center_value <= '0;
		end else begin
			case (state)
				LOAD: begin
					// tension starts from rest
					center_value <= '0;
					if (load_write) begin
						load_ack  <= 1'b1;
						load_last <= (load_row == row_t'(GRID_ROWS - 1)) &&
							(load_col == col_t'(GRID_COLS - 1));
					end else if (load_ack && !load_req) begin
						load_ack <= 1'b0;
						if (load_last)
							state <= SETTLE;
					end
				end
				SETTLE: state <= START;
				START: begin
					sweep_done <= 1'b0;
					state      <= READ_WAIT;
				end
				READ_WAIT: state <= WRITE;
				WRITE: state <= SHIFT;
				SHIFT: begin
					if (row_last)
						sweep_done <= 1'b1;
					state <= NEXT_ROW;
				end
				NEXT_ROW: state <= sweep_done ? SEND : WRITE;
				SEND: begin
					// new center becomes sample and tension source together
					sample_req   <= 1'b1;
					center_value <= center_hold;
					state        <= RELEASE;
				end
				RELEASE: begin
					if (sample_req && sample_ack)
						sample_req <= 1'b0;
					else if (!sample_req && !sample_ack)
						state <= START;
				end
				default: state <= LOAD;
			endcase
		end
	end

	// center node result, held until the end of the step
	always_ff @(posedge clk) begin
		if (state == WRITE && row == row_t'(CENTER_ROW))
			center_hold <= center_next;
	end

endmodule

// File: src/tension_calc.sv
`timescale 1ns/1ps

module tension_calc (
	input  drum_pkg::node_t center_value,
	output drum_pkg::node_t rho_eff
);
	import drum_pkg::*;

	node_t scaled;
	node_t squared;
	node_t raw_rho;

	// gain ahead of the square keeps the product small
	assign scaled = center_value >>> GAIN_SHIFT;

	assign squared = fx_mul(scaled, scaled);

	// tension grows with displacement
	assign raw_rho = squared + RHO_0;

	// stay below 0.5 so the scheme remains stable
	assign rho_eff = (raw_rho < RHO_MAX) ? raw_rho : RHO_MAX;

endmodule
